// File: id_stage_pkg.sv
package id_stage_pkg;

    parameter int XLEN     = 32;
    parameter int REG_AW   = 5;
    parameter int NUM_REGS = 32;
    parameter int INST_W   = 32;
    parameter int RA_REG   = 1;

    // major opcode, inst[31:26]
    localparam logic [5:0] OPC_MAJ_GRP0      = 6'h00;
    localparam logic [5:0] OPC_MAJ_LU12I     = 6'h05;
    localparam logic [5:0] OPC_MAJ_PCADDU12I = 6'h07;
    localparam logic [5:0] OPC_MAJ_MEM       = 6'h0a;
    localparam logic [5:0] OPC_MAJ_JIRL      = 6'h13;
    localparam logic [5:0] OPC_MAJ_B         = 6'h14;
    localparam logic [5:0] OPC_MAJ_BL        = 6'h15;
    localparam logic [5:0] OPC_MAJ_BEQ       = 6'h16;
    localparam logic [5:0] OPC_MAJ_BNE       = 6'h17;
    localparam logic [5:0] OPC_MAJ_BLT       = 6'h18;
    localparam logic [5:0] OPC_MAJ_BGE       = 6'h19;
    localparam logic [5:0] OPC_MAJ_BLTU      = 6'h1a;
    localparam logic [5:0] OPC_MAJ_BGEU      = 6'h1b;

    // inst[25:22]
    localparam logic [3:0] OPC_MID_3R     = 4'h0;
    localparam logic [3:0] OPC_MID_SHIFTI = 4'h1;
    localparam logic [3:0] OPC_MID_SLTI   = 4'h8;
    localparam logic [3:0] OPC_MID_SLTUI  = 4'h9;
    localparam logic [3:0] OPC_MID_ADDI   = 4'ha;
    localparam logic [3:0] OPC_MID_ANDI   = 4'hd;
    localparam logic [3:0] OPC_MID_ORI    = 4'he;
    localparam logic [3:0] OPC_MID_XORI   = 4'hf;
    localparam logic [3:0] OPC_MID_LDW    = 4'h2;
    localparam logic [3:0] OPC_MID_STW    = 4'h6;

    // inst[21:20]
    localparam logic [1:0] OPC_SUB_3R     = 2'h1;
    localparam logic [1:0] OPC_SUB_SHIFTI = 2'h0;

    // inst[19:15]
    localparam logic [4:0] OPC_FN_ADD  = 5'h00;
    localparam logic [4:0] OPC_FN_SUB  = 5'h02;
    localparam logic [4:0] OPC_FN_SLT  = 5'h04;
    localparam logic [4:0] OPC_FN_SLTU = 5'h05;
    localparam logic [4:0] OPC_FN_NOR  = 5'h08;
    localparam logic [4:0] OPC_FN_AND  = 5'h09;
    localparam logic [4:0] OPC_FN_OR   = 5'h0a;
    localparam logic [4:0] OPC_FN_XOR  = 5'h0b;
    localparam logic [4:0] OPC_FN_SLL  = 5'h0e;
    localparam logic [4:0] OPC_FN_SRL  = 5'h0f;
    localparam logic [4:0] OPC_FN_SRA  = 5'h10;
    localparam logic [4:0] OPC_FN_SLLI = 5'h01;
    localparam logic [4:0] OPC_FN_SRLI = 5'h09;
    localparam logic [4:0] OPC_FN_SRAI = 5'h11;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_B, BR_BL, BR_JIRL
    } br_kind_e;

    typedef struct packed {
        alu_op_e               alu_op;
        br_kind_e              br_kind;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_is_rd;
        logic                  need_r1;
        logic                  need_r2;
        logic                  res_from_mem;
        logic                  mem_we;
        logic                  rf_we;
        logic [REG_AW-1:0]     dest;
        logic [XLEN-1:0]       imm;
    } decode_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [INST_W-1:0] inst;
    } fs_to_ds_t;

    typedef struct packed {
        alu_op_e           alu_op;
        logic              res_from_mem;
        logic              mem_we;
        logic              rf_we;
        logic [REG_AW-1:0] rf_waddr;
        logic [XLEN-1:0]   alu_src1;
        logic [XLEN-1:0]   alu_src2;
        logic [XLEN-1:0]   rkd_value;
        logic [XLEN-1:0]   pc;
    } ds_to_es_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } rf_wr_t;

    typedef struct packed {
        logic              res_from_mem;
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } es_fwd_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_t;

endpackage

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import id_stage_pkg::*; (
    input  logic [INST_W-1:0] inst,
    output decode_t           dec
);

    logic [5:0]        op_31_26;
    logic [3:0]        op_25_22;
    logic [1:0]        op_21_20;
    logic [4:0]        op_19_15;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rk;
    logic [XLEN-1:0]   imm_ui5;
    logic [XLEN-1:0]   imm_si12;
    logic [XLEN-1:0]   imm_ui12;
    logic [XLEN-1:0]   imm_si20;
    // register-register, register-immediate and conditional branch forms
    logic              r3;
    logic              ri;
    logic              cb;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rk       = inst[14:10];

    assign imm_ui5  = {27'b0, rk};
    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui12 = {20'b0, inst[21:10]};
    assign imm_si20 = {inst[24:5], 12'b0};

    always_comb begin
        dec      = '0;
        dec.dest = rd;
        r3       = 1'b0;
        ri       = 1'b0;
        cb       = 1'b0;
        case (op_31_26)
            OPC_MAJ_GRP0: begin
                if (op_25_22 == OPC_MID_3R && op_21_20 == OPC_SUB_3R) begin
                    r3 = 1'b1;
                    case (op_19_15)
                        OPC_FN_ADD:  dec.alu_op = ALU_ADD;
                        OPC_FN_SUB:  dec.alu_op = ALU_SUB;
                        OPC_FN_SLT:  dec.alu_op = ALU_SLT;
                        OPC_FN_SLTU: dec.alu_op = ALU_SLTU;
                        OPC_FN_NOR:  dec.alu_op = ALU_NOR;
                        OPC_FN_AND:  dec.alu_op = ALU_AND;
                        OPC_FN_OR:   dec.alu_op = ALU_OR;
                        OPC_FN_XOR:  dec.alu_op = ALU_XOR;
                        OPC_FN_SLL:  dec.alu_op = ALU_SLL;
                        OPC_FN_SRL:  dec.alu_op = ALU_SRL;
                        OPC_FN_SRA:  dec.alu_op = ALU_SRA;
                        default:     r3 = 1'b0;
                    endcase
                end else if (op_25_22 == OPC_MID_SHIFTI && op_21_20 == OPC_SUB_SHIFTI) begin
                    ri      = 1'b1;
                    dec.imm = imm_ui5;
                    case (op_19_15)
                        OPC_FN_SLLI: dec.alu_op = ALU_SLL;
                        OPC_FN_SRLI: dec.alu_op = ALU_SRL;
                        OPC_FN_SRAI: dec.alu_op = ALU_SRA;
                        default:     ri = 1'b0;
                    endcase
                end else begin
                    ri      = 1'b1;
                    dec.imm = imm_si12;
                    case (op_25_22)
                        OPC_MID_SLTI:  dec.alu_op = ALU_SLT;
                        OPC_MID_SLTUI: dec.alu_op = ALU_SLTU;
                        OPC_MID_ADDI:  dec.alu_op = ALU_ADD;
                        OPC_MID_ANDI:  dec.alu_op = ALU_AND;
                        OPC_MID_ORI:   dec.alu_op = ALU_OR;
                        OPC_MID_XORI:  dec.alu_op = ALU_XOR;
                        default:       ri = 1'b0;
                    endcase
                    // logical immediates are zero extended
                    if (dec.alu_op inside {ALU_AND, ALU_OR, ALU_XOR}) begin
                        dec.imm = imm_ui12;
                    end
                end
            end
            OPC_MAJ_LU12I, OPC_MAJ_PCADDU12I: begin
                if (!inst[25]) begin
                    dec.alu_op      = (op_31_26 == OPC_MAJ_LU12I) ? ALU_LUI : ALU_ADD;
                    dec.src1_is_pc  = (op_31_26 == OPC_MAJ_PCADDU12I);
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = imm_si20;
                    dec.rf_we       = 1'b1;
                end
            end
            OPC_MAJ_MEM: begin
                if (op_25_22 == OPC_MID_LDW || op_25_22 == OPC_MID_STW) begin
                    dec.alu_op       = ALU_ADD;
                    dec.src2_is_imm  = 1'b1;
                    dec.imm          = imm_si12;
                    dec.need_r1      = 1'b1;
                    dec.res_from_mem = (op_25_22 == OPC_MID_LDW);
                    dec.rf_we        = (op_25_22 == OPC_MID_LDW);
                    // store data comes from rd
                    dec.mem_we       = (op_25_22 == OPC_MID_STW);
                    dec.need_r2      = (op_25_22 == OPC_MID_STW);
                    dec.src2_is_rd   = (op_25_22 == OPC_MID_STW);
                end
            end
            OPC_MAJ_JIRL, OPC_MAJ_BL: begin
                // link value is pc + 4
                dec.alu_op      = ALU_ADD;
                dec.br_kind     = (op_31_26 == OPC_MAJ_JIRL) ? BR_JIRL : BR_BL;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm         = 32'd4;
                dec.need_r1     = (op_31_26 == OPC_MAJ_JIRL);
                dec.rf_we       = 1'b1;
                if (op_31_26 == OPC_MAJ_BL) begin
                    dec.dest = REG_AW'(RA_REG);
                end
            end
            OPC_MAJ_B:    dec.br_kind = BR_B;
            OPC_MAJ_BEQ:  cb = 1'b1;
            OPC_MAJ_BNE:  cb = 1'b1;
            OPC_MAJ_BLT:  cb = 1'b1;
            OPC_MAJ_BGE:  cb = 1'b1;
            OPC_MAJ_BLTU: cb = 1'b1;
            OPC_MAJ_BGEU: cb = 1'b1;
            default: ;
        endcase

        if (r3 || ri) begin
            dec.need_r1     = 1'b1;
            dec.need_r2     = r3;
            dec.src2_is_imm = ri;
            dec.rf_we       = 1'b1;
        end
        if (cb) begin
            dec.br_kind    = br_kind_e'(op_31_26 - OPC_MAJ_BEQ + 6'd1);
            dec.need_r1    = 1'b1;
            dec.need_r2    = 1'b1;
            dec.src2_is_rd = 1'b1;
        end
    end

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile import id_stage_pkg::*; (
    input  logic              clk,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2,
    input  rf_wr_t            wr
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: operand_forward.sv
`timescale 1ns/1ps

module operand_forward import id_stage_pkg::*; (
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    input  logic              need_r1,
    input  logic              need_r2,
    input  logic [XLEN-1:0]   rdata1,
    input  logic [XLEN-1:0]   rdata2,
    input  es_fwd_t           es_fwd,
    input  rf_wr_t            ms_fwd,
    input  rf_wr_t            ws_fwd,
    output logic [XLEN-1:0]   rj_value,
    output logic [XLEN-1:0]   rkd_value,
    output logic              load_use_stall
);

    logic hit1_es;
    logic hit1_ms;
    logic hit1_ws;
    logic hit2_es;
    logic hit2_ms;
    logic hit2_ws;

    // r0 never matches a pending write
    assign hit1_es = (raddr1 != '0) && es_fwd.we && (raddr1 == es_fwd.waddr);
    assign hit1_ms = (raddr1 != '0) && ms_fwd.we && (raddr1 == ms_fwd.waddr);
    assign hit1_ws = (raddr1 != '0) && ws_fwd.we && (raddr1 == ws_fwd.waddr);
    assign hit2_es = (raddr2 != '0) && es_fwd.we && (raddr2 == es_fwd.waddr);
    assign hit2_ms = (raddr2 != '0) && ms_fwd.we && (raddr2 == ms_fwd.waddr);
    assign hit2_ws = (raddr2 != '0) && ws_fwd.we && (raddr2 == ws_fwd.waddr);

    // youngest producer wins
    assign rj_value  = hit1_es ? es_fwd.wdata :
                       hit1_ms ? ms_fwd.wdata :
                       hit1_ws ? ws_fwd.wdata :
                       rdata1;

    assign rkd_value = hit2_es ? es_fwd.wdata :
                       hit2_ms ? ms_fwd.wdata :
                       hit2_ws ? ws_fwd.wdata :
                       rdata2;

    // load data is not ready until mem
    assign load_use_stall = es_fwd.res_from_mem &&
                            ((hit1_es && need_r1) || (hit2_es && need_r2));

endmodule

// File: branch_unit.sv
`timescale 1ns/1ps

module branch_unit import id_stage_pkg::*; (
    input  br_kind_e        br_kind,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rj_value,
    input  logic [XLEN-1:0] rkd_value,
    input  logic [XLEN-1:0] imm16_offs,
    input  logic [XLEN-1:0] imm26_offs,
    output logic            taken_cond,
    output logic [XLEN-1:0] target
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rj_value == rkd_value);
    assign lt_s = ($signed(rj_value) < $signed(rkd_value));
    assign lt_u = (rj_value < rkd_value);

    always_comb begin
        case (br_kind)
            BR_BEQ:  taken_cond = eq;
            BR_BNE:  taken_cond = !eq;
            BR_BLT:  taken_cond = lt_s;
            BR_BGE:  taken_cond = !lt_s;
            BR_BLTU: taken_cond = lt_u;
            BR_BGEU: taken_cond = !lt_u;
            BR_B, BR_BL, BR_JIRL: taken_cond = 1'b1;
            default: taken_cond = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    always_comb begin
        case (br_kind)
            BR_JIRL:     target = rj_value + imm16_offs;
            BR_B, BR_BL: target = pc + imm26_offs;
            default:     target = pc + imm16_offs;
        endcase
    end

endmodule

// File: id_stage.sv
`timescale 1ns/1ps

module id_stage import id_stage_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds,
    output logic      ds_allowin,
    input  logic      es_allowin,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es,
    output br_t       br,
    input  es_fwd_t   es_fwd,
    input  rf_wr_t    ms_fwd,
    input  rf_wr_t    ws_fwd
);

    logic              ds_valid;
    fs_to_ds_t         ds_q;
    logic              ready_go;
    logic              load_use_stall;
    decode_t           dec;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rj;
    logic [REG_AW-1:0] rk;
    logic [15:0]       i16;
    logic [25:0]       i26;
    logic [XLEN-1:0]   imm16_offs;
    logic [XLEN-1:0]   imm26_offs;
    logic [REG_AW-1:0] raddr2;
    logic [XLEN-1:0]   rf_rdata1;
    logic [XLEN-1:0]   rf_rdata2;
    logic [XLEN-1:0]   rj_value;
    logic [XLEN-1:0]   rkd_value;
    logic              taken_cond;
    logic [XLEN-1:0]   target;

    assign ready_go       = !load_use_stall;
    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    // redirect only when the branch actually hands off to execute
    assign br.taken  = taken_cond && ds_to_es_valid && es_allowin;
    assign br.target = target;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (br.taken) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_q <= '0;
        end else if (fs_to_ds_valid && ds_allowin && !br.taken) begin
            ds_q <= fs_to_ds;
        end
    end

    assign rd  = ds_q.inst[4:0];
    assign rj  = ds_q.inst[9:5];
    assign rk  = ds_q.inst[14:10];
    assign i16 = ds_q.inst[25:10];
    assign i26 = {ds_q.inst[9:0], ds_q.inst[25:10]};

    assign imm16_offs = {{14{i16[15]}}, i16, 2'b0};
    assign imm26_offs = {{4{i26[25]}}, i26, 2'b0};

    // stores and compares read rd on the second port
    assign raddr2 = dec.src2_is_rd ? rd : rk;

    inst_decoder u_dec (
        .inst (ds_q.inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_fwd)
    );

    operand_forward u_fwd (
        .raddr1         (rj),
        .raddr2         (raddr2),
        .need_r1        (dec.need_r1),
        .need_r2        (dec.need_r2),
        .rdata1         (rf_rdata1),
        .rdata2         (rf_rdata2),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .load_use_stall (load_use_stall)
    );

    branch_unit u_br (
        .br_kind    (dec.br_kind),
        .pc         (ds_q.pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .imm16_offs (imm16_offs),
        .imm26_offs (imm26_offs),
        .taken_cond (taken_cond),
        .target     (target)
    );

    always_comb begin
        ds_to_es.alu_op       = dec.alu_op;
        ds_to_es.res_from_mem = dec.res_from_mem;
        ds_to_es.mem_we       = dec.mem_we;
        ds_to_es.rf_we        = dec.rf_we;
        ds_to_es.rf_waddr     = dec.dest;
        ds_to_es.alu_src1     = dec.src1_is_pc ? ds_q.pc : rj_value;
        ds_to_es.alu_src2     = dec.src2_is_imm ? dec.imm : rkd_value;
        ds_to_es.rkd_value    = rkd_value;
        ds_to_es.pc           = ds_q.pc;
    end

endmodule

// File: id_stage_props.sv
`timescale 1ns/1ps

module id_stage_props import id_stage_pkg::*; (
    input logic      clk,
    input logic      resetn,
    input logic      ds_to_es_valid,
    input logic      es_allowin,
    input ds_to_es_t ds_to_es,
    input br_t       br
);

    no_valid_in_reset: assert property (@(posedge clk)
        !resetn |-> (ds_to_es_valid !== 1'b1))
        else $error("ds_to_es_valid high during reset");

    // a taken branch empties the stage and drops the fetch slot
    flush_on_taken: assert property (@(posedge clk) disable iff (!resetn)
        br.taken |=> !ds_to_es_valid)
        else $error("stage not emptied after a taken branch");

    hold_pc: assert property (@(posedge clk) disable iff (!resetn)
        (ds_to_es_valid && !es_allowin) |=> $stable(ds_to_es.pc))
        else $error("pc changed under back-pressure");

endmodule

bind id_stage id_stage_props u_props (
    .clk            (clk),
    .resetn         (resetn),
    .ds_to_es_valid (ds_to_es_valid),
    .es_allowin     (es_allowin),
    .ds_to_es       (ds_to_es),
    .br             (br)
);

// File: tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage import id_stage_pkg::*; ();

    localparam int MAX_REC = 64;

    logic      clk;
    logic      resetn;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds;
    logic      ds_allowin;
    logic      es_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es;
    br_t       br;
    es_fwd_t   es_fwd;
    rf_wr_t    ms_fwd;
    rf_wr_t    ws_fwd;
    rf_wr_t    ws_cur;

    string       rec_kind [MAX_REC];
    logic [31:0] rec_f [MAX_REC][13];
    int          n_rec;
    logic        loaded;
    int          test_errs;
    int          n_tests;
    int          n_failed;
    int          n_instr;
    int          n_issued;
    int unsigned seed_val;

    id_stage u_dut (
        .clk            (clk),
        .resetn         (resetn),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .br             (br),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ends the run when the tests take too long
    initial begin
        wait (loaded);
        #((n_rec + NUM_REGS + 10) * 20 * 10);
        $display("timeout: the test sequence did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    always @(posedge clk) begin
        if (resetn && ds_to_es_valid && es_allowin) begin
            n_issued++;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Error: time %0t %s expected %b got %b", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (got !== exp) begin
            $display("Error: time %0t %s expected %h got %h", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic check_bundle(input ds_to_es_t exp, input ds_to_es_t got);
        compare_field("ds_to_es.alu_op", 32'(exp.alu_op), 32'(got.alu_op));
        compare_field("ds_to_es.res_from_mem", 32'(exp.res_from_mem), 32'(got.res_from_mem));
        compare_field("ds_to_es.mem_we", 32'(exp.mem_we), 32'(got.mem_we));
        compare_field("ds_to_es.rf_we", 32'(exp.rf_we), 32'(got.rf_we));
        compare_field("ds_to_es.rf_waddr", 32'(exp.rf_waddr), 32'(got.rf_waddr));
        compare_field("ds_to_es.alu_src1", exp.alu_src1, got.alu_src1);
        compare_field("ds_to_es.alu_src2", exp.alu_src2, got.alu_src2);
        compare_field("ds_to_es.rkd_value", exp.rkd_value, got.rkd_value);
        compare_field("ds_to_es.pc", exp.pc, got.pc);
    endtask

    // target only matters when taken
    task automatic check_br(input br_t exp, input br_t got);
        check_level("br.taken", exp.taken, got.taken);
        if (exp.taken) begin
            compare_field("br.target", exp.target, got.target);
        end
    endtask

    task automatic wait_valid();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (ds_to_es_valid !== 1'b1 && cnt < 20) begin
            @(negedge clk);
            cnt++;
        end
        if (ds_to_es_valid !== 1'b1) begin
            $display("ds_to_es_valid did not rise within 20 cycles at time %0t", $time);
            test_errs++;
        end
    endtask

    task automatic read_records();
        int    fd;
        int    code;
        string kind;
        string line;
        int    nf;
        fd    = $fopen("id_stage_testdata.txt", "r");
        n_rec = 0;
        if (fd == 0) begin
            $display("cannot open id_stage_testdata.txt");
        end else begin
            while (!$feof(fd) && n_rec < MAX_REC) begin
                code = $fscanf(fd, "%s", kind);
                if (code != 1) begin
                    break;
                end
                if (kind == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    nf = (kind == "P") ? 2 : (kind == "F") ? 10 : 13;
                    rec_kind[n_rec] = kind;
                    for (int i = 0; i < nf; i++) begin
                        code = $fscanf(fd, "%h", rec_f[n_rec][i]);
                    end
                    n_rec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_instr(input int r);
        ds_to_es_t exp;
        br_t       exp_br;
        int        gap;
        exp.pc           = rec_f[r][0];
        exp.alu_op       = alu_op_e'(rec_f[r][3][3:0]);
        exp.res_from_mem = rec_f[r][4][0];
        exp.mem_we       = rec_f[r][5][0];
        exp.rf_we        = rec_f[r][6][0];
        exp.rf_waddr     = rec_f[r][7][REG_AW-1:0];
        exp.alu_src1     = rec_f[r][8];
        exp.alu_src2     = rec_f[r][9];
        exp.rkd_value    = rec_f[r][10];
        exp_br.taken     = rec_f[r][11][0];
        exp_br.target    = rec_f[r][12];
        test_errs        = 0;
        gap              = $urandom % 4;

        fs_to_ds_valid = 1'b1;
        fs_to_ds.pc    = rec_f[r][0];
        fs_to_ds.inst  = rec_f[r][1];
        es_allowin     = 1'b0;
        @(negedge clk);
        check_level("ds_allowin", 1'b1, ds_allowin);
        step();
        fs_to_ds_valid = 1'b0;

        if (rec_f[r][2][0]) begin
            es_allowin = 1'b1;
            repeat (2) begin
                @(negedge clk);
                check_level("ds_to_es_valid", 1'b0, ds_to_es_valid);
                check_level("ds_allowin", 1'b0, ds_allowin);
                step();
            end
            // load moves on to mem
            ms_fwd.we    = es_fwd.we;
            ms_fwd.waddr = es_fwd.waddr;
            ms_fwd.wdata = es_fwd.wdata;
            es_fwd       = '0;
            es_allowin   = 1'b0;
        end

        wait_valid();
        for (int i = 0; i < gap; i++) begin
            check_level("ds_to_es_valid", 1'b1, ds_to_es_valid);
            check_level("ds_allowin", 1'b0, ds_allowin);
            check_level("br.taken", 1'b0, br.taken);
            check_bundle(exp, ds_to_es);
            step();
            @(negedge clk);
        end

        step();
        es_allowin = 1'b1;
        // wrong-path fetch slot must be dropped by the redirect
        if (exp_br.taken) begin
            fs_to_ds_valid = 1'b1;
            fs_to_ds.pc    = 32'hbad0_0000;
            fs_to_ds.inst  = 32'h0010_0823;
        end
        @(negedge clk);
        check_level("ds_to_es_valid", 1'b1, ds_to_es_valid);
        check_bundle(exp, ds_to_es);
        check_br(exp_br, br);
        step();
        es_allowin     = 1'b0;
        fs_to_ds_valid = 1'b0;
        @(negedge clk);
        check_level("ds_to_es_valid", 1'b0, ds_to_es_valid);
        step();

        n_tests++;
        n_instr++;
        if (test_errs == 0) begin
            $display("test %0d pc %h inst %h: ok", n_tests, exp.pc, rec_f[r][1]);
        end else begin
            n_failed++;
            $display("test %0d pc %h inst %h: FAILED (%0d errors)", n_tests, exp.pc,
                     rec_f[r][1], test_errs);
        end
    endtask

    initial begin
        seed_val       = $urandom(73653);
        loaded         = 1'b0;
        resetn         = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds       = '0;
        es_allowin     = 1'b0;
        es_fwd         = '0;
        ms_fwd         = '0;
        ws_fwd         = '0;
        ws_cur         = '0;
        n_tests        = 0;
        n_failed       = 0;
        n_instr        = 0;
        n_issued       = 0;

        read_records();
        loaded = 1'b1;

        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;

        // background fill of the register file
        for (int i = 1; i < NUM_REGS; i++) begin
            ws_fwd = '{we: 1'b1, waddr: REG_AW'(i), wdata: 32'(i) * 32'h0101_0101};
            step();
        end
        ws_fwd = '0;

        for (int r = 0; r < n_rec; r++) begin
            if (rec_kind[r] == "P") begin
                ws_fwd = '{we: 1'b1, waddr: rec_f[r][0][REG_AW-1:0], wdata: rec_f[r][1]};
                step();
                ws_fwd = ws_cur;
            end else if (rec_kind[r] == "F") begin
                es_fwd.we           = rec_f[r][0][0];
                es_fwd.res_from_mem = rec_f[r][1][0];
                es_fwd.waddr        = rec_f[r][2][REG_AW-1:0];
                es_fwd.wdata        = rec_f[r][3];
                ms_fwd.we           = rec_f[r][4][0];
                ms_fwd.waddr        = rec_f[r][5][REG_AW-1:0];
                ms_fwd.wdata        = rec_f[r][6];
                ws_cur.we           = rec_f[r][7][0];
                ws_cur.waddr        = rec_f[r][8][REG_AW-1:0];
                ws_cur.wdata        = rec_f[r][9];
                ws_fwd              = ws_cur;
            end else begin
                run_instr(r);
            end
        end

        if (n_issued != n_instr) begin
            $display("instruction count mismatch: offered %0d, issued %0d", n_instr, n_issued);
            n_failed++;
        end
        $display("tests %0d, passed %0d, failed %0d", n_tests, n_tests - n_failed, n_failed);
        if (n_failed == 0 && n_tests > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: id_stage.f
id_stage_pkg.sv
inst_decoder.sv
regfile.sv
operand_forward.sv
branch_unit.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - id_stage_pkg.sv
  - inst_decoder.sv
  - regfile.sv
  - operand_forward.sv
  - branch_unit.sv
  - id_stage.sv
  - target: simulation
    files:
      - id_stage_props.sv
      - tb_id_stage.sv

// File: id_stage_testdata.txt
# P reg value | F es_we es_mem es_addr es_data ms_we ms_addr ms_data ws_we ws_addr ws_data
# I pc inst stall alu_op res_from_mem mem_we rf_we waddr src1 src2 rkd taken target
P 01 00000010
P 02 00000003
P 04 fffffff0
P 05 12345678
I 1c000000 00100823 0 1 0 0 1 03 00000010 00000003 00000003 0 00000000
I 1c000004 001110a6 0 2 0 0 1 06 12345678 fffffff0 fffffff0 0 00000000
I 1c000008 00128487 0 4 0 0 1 07 fffffff0 00000010 00000010 0 00000000
I 1c00000c 00140828 0 6 0 0 1 08 00000010 00000003 00000003 0 00000000
I 1c000010 00488c89 0 b 0 0 1 09 fffffff0 00000003 03030303 0 00000000
I 1c000014 02bffc2a 0 1 0 0 1 0a 00000010 ffffffff 1f1f1f1f 0 00000000
I 1c000018 0363fc8b 0 5 0 0 1 0b fffffff0 000008ff 1f1f1f1f 0 00000000
I 1c00001c 1500002c 0 c 0 0 1 0c 00000010 80001000 00000000 0 00000000
I 1c000020 1c00002d 0 1 0 0 1 0d 1c000020 00001000 00000000 0 00000000
I 1c000024 288020ae 0 1 1 0 1 0e 12345678 00000008 08080808 0 00000000
I 1c000028 29bff022 0 1 0 1 0 02 00000010 fffffffc 00000003 0 00000000
F 1 0 01 aaaa0001 1 01 bbbb0001 1 01 cccc0001
I 1c00002c 00100823 0 1 0 0 1 03 aaaa0001 00000003 00000003 0 00000000
F 0 0 00 00000000 1 01 bbbb0001 1 01 cccc0001
I 1c000030 00100823 0 1 0 0 1 03 bbbb0001 00000003 00000003 0 00000000
F 0 0 00 00000000 0 00 00000000 1 01 cccc0001
I 1c000034 00100823 0 1 0 0 1 03 cccc0001 00000003 00000003 0 00000000
F 1 1 02 77770002 0 00 00000000 0 00 00000000
I 1c000038 00100823 1 1 0 0 1 03 cccc0001 77770002 77770002 0 00000000
F 1 1 01 55550001 0 00 00000000 0 00 00000000
I 1c00003c 1500002c 0 c 0 0 1 0c 55550001 80001000 00000000 0 00000000
F 0 0 00 00000000 0 00 00000000 0 00 00000000
I 1c000200 58001042 0 0 0 0 0 02 00000003 00000003 00000003 1 1c000210
I 1c000204 5c001042 0 0 0 0 0 02 00000003 00000003 00000003 0 00000000
I 1c000208 67fff881 0 0 0 0 0 01 fffffff0 cccc0001 cccc0001 1 1c000200
I 1c00020c 68000424 0 0 0 0 0 04 cccc0001 fffffff0 fffffff0 1 1c000210
I 1c000214 63fff881 0 0 0 0 0 01 fffffff0 cccc0001 cccc0001 0 00000000
I 1c000218 6ffff881 0 0 0 0 0 01 fffffff0 cccc0001 cccc0001 1 1c000210
I 1c000210 50040000 0 0 0 0 0 00 00000000 00000000 00000000 1 1c000610
I 1c000300 57ffc3ff 0 1 0 0 1 01 1c000300 00000004 10101010 1 1c0002c0
I 1c000304 4c0008a7 0 1 0 0 1 07 1c000304 00000004 00000003 1 12345680
